//--- tb.f
+incdir+src
src/conv_pkg.sv
src/pe_if.sv
src/conv_ctrl.sv
src/line_buffer.sv
src/conv_pe.sv
src/conv_top.sv
testbench/conv_checker.sv
testbench/tb_conv.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_conv -o Vtb_conv \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_conv > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "simulation passed"
exit 0

//--- testbench/tb_conv.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module tb_conv;
    import conv_pkg::*;

    localparam int W          = `CONV_WIDTH;
    localparam int FRAC       = `CONV_FRAC_BITS;
    localparam int K          = `CONV_KERNEL_SIZE;
    localparam int P          = `CONV_PIC_SIZE;
    localparam int PAD        = K / 2;
    localparam int KSQ        = K * K;
    localparam int NPIX       = P * P;
    localparam int RST_CYCLES = 10;
    localparam int RUN_CYCLES = 3 * (KSQ + NPIX) + 2 * NPIX + 4 * P + 40;  // Gappy worst case
    localparam int RUNS       = 8;
    localparam int WD_CYCLES  = 4 * (RST_CYCLES + RUNS * RUN_CYCLES);
    localparam longint PIX_MAX = (longint'(1) << (W - 1)) - 1;
    localparam longint PIX_MIN = -PIX_MAX - 1;

    logic  clk, rst_n, conv_start;
    pix_t  weight, pic, conv_result;
    logic  weight_valid, need_weight, pic_valid, need_pic;
    addr_t conv_result_addr;
    logic  conv_result_valid, conv_finish;

    pix_t  img [NPIX];       // Image of the current run
    pix_t  kern [KSQ];       // Kernel, row-major
    pix_t  got [NPIX];       // Results by address
    pix_t  saved [NPIX];     // Gap-free reference run
    int    seen [NPIX];      // Hits per address
    int    errors, checks, result_count, finish_count;
    addr_t last_addr;

    conv_top dut (
        .clk (clk), .rst_n (rst_n), .conv_start (conv_start),
        .weight (weight), .weight_valid (weight_valid), .need_weight (need_weight),
        .pic (pic), .pic_valid (pic_valid), .need_pic (need_pic),
        .conv_result (conv_result), .conv_result_addr (conv_result_addr),
        .conv_result_valid (conv_result_valid), .conv_finish (conv_finish)
    );

    always #10 clk = ~clk;   // 20 ns period

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Arithmetic rule: padded MAC, floor shift, clamp
    function automatic pix_t model_pixel(input int r, input int c);
        longint acc;
        int     ir, ic;
        acc = 0;
        for (int ki = 0; ki < K; ki++) begin
            for (int kj = 0; kj < K; kj++) begin
                ir = r + ki - PAD;
                ic = c + kj - PAD;
                if (ir >= 0 && ir < P && ic >= 0 && ic < P) begin
                    acc += longint'(img[ir * P + ic]) * longint'(kern[ki * K + kj]);
                end
            end
        end
        acc = acc >>> FRAC;
        if (acc > PIX_MAX) acc = PIX_MAX;
        else if (acc < PIX_MIN) acc = PIX_MIN;
        return pix_t'(acc);
    endfunction

    // Collector, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (rst_n && conv_result_valid) begin
            if (result_count != 0 && conv_result_addr <= last_addr) begin
                errors++;
                $display("result address %0d arrived out of raster order", conv_result_addr);
            end
            got[conv_result_addr] = conv_result;
            seen[conv_result_addr]++;
            last_addr = conv_result_addr;
            result_count++;
        end
        if (rst_n && conv_finish) begin
            finish_count++;
            check("conv_result_valid at conv_finish", conv_result_valid, 1);
            check("conv_result_addr at conv_finish", conv_result_addr, NPIX - 1);
        end
    end

    task automatic feed_weights(input bit gaps);
        int i;
        i = 0;
        while (i < KSQ) begin
            @(posedge clk);
            if (gaps && $urandom_range(2, 0) == 0) begin
                weight_valid <= 1'b0;               // Random bubble
            end else begin
                weight_valid <= 1'b1;
                weight       <= kern[i];
            end
            @(negedge clk);
            if (weight_valid && need_weight) i++;   // Taken at the coming edge
        end
        @(posedge clk);
        weight_valid <= 1'b0;
    endtask

    task automatic feed_pixels(input bit gaps);
        int i;
        i = 0;
        while (i < NPIX) begin
            @(posedge clk);
            if (gaps && $urandom_range(2, 0) == 0) begin
                pic_valid <= 1'b0;
            end else begin
                pic_valid <= 1'b1;
                pic       <= img[i];
            end
            @(negedge clk);
            if (pic_valid && need_pic) i++;
        end
        @(posedge clk);
        pic_valid <= 1'b0;
    endtask

    // One full convolution, optionally with a stray start in the middle
    task automatic run_conv(input bit gaps, input bit poke);
        for (int a = 0; a < NPIX; a++) seen[a] = 0;
        result_count = 0;
        finish_count = 0;
        @(posedge clk);
        conv_start <= 1'b1;
        @(posedge clk);
        conv_start <= 1'b0;
        fork
            feed_weights(gaps);
            feed_pixels(gaps);
            if (poke) begin
                repeat (3 * P) @(posedge clk);
                conv_start <= 1'b1;                 // Must be ignored while busy
                @(posedge clk);
                conv_start <= 1'b0;
            end
        join
        while (finish_count == 0) @(posedge clk);
        repeat (4) @(posedge clk);                  // Let the FSM settle in IDLE
        check("conv_finish pulse count", finish_count, 1);
        check("conv_result_valid count", result_count, NPIX);
    endtask

    task automatic randomize_data();
        for (int a = 0; a < NPIX; a++) img[a] = pix_t'($urandom);
        for (int i = 0; i < KSQ; i++) kern[i] = pix_t'(int'($urandom_range(63, 0)) - 32);
    endtask

    task automatic verify_model();
        for (int a = 0; a < NPIX; a++) begin
            check($sformatf("conv_result_addr %0d hits", a), seen[a], 1);
            check($sformatf("conv_result[%0d]", a), got[a], model_pixel(a / P, a % P));
        end
    endtask

    task automatic test_identity();
        for (int i = 0; i < KSQ; i++) kern[i] = '0;
        kern[KSQ / 2] = pix_t'(1 << FRAC);          // 1.0 at the centre
        for (int a = 0; a < NPIX; a++) img[a] = pix_t'($urandom);
        run_conv(1'b0, 1'b0);
        for (int a = 0; a < NPIX; a++) begin
            check($sformatf("conv_result_addr %0d hits", a), seen[a], 1);
            check($sformatf("conv_result[%0d]", a), got[a], img[a]);
        end
    endtask

    task automatic test_random();
        randomize_data();
        run_conv(1'b0, 1'b0);
        verify_model();
    endtask

    task automatic test_saturation();
        for (int i = 0; i < KSQ; i++) kern[i] = pix_t'(PIX_MAX);
        for (int a = 0; a < NPIX; a++) img[a] = pix_t'(PIX_MAX);
        run_conv(1'b0, 1'b0);
        for (int a = 0; a < NPIX; a++) begin
            check($sformatf("conv_result[%0d] high clamp", a), got[a], pix_t'(PIX_MAX));
        end
        for (int a = 0; a < NPIX; a++) img[a] = pix_t'(PIX_MIN);
        run_conv(1'b0, 1'b0);
        for (int a = 0; a < NPIX; a++) begin
            check($sformatf("conv_result[%0d] low clamp", a), got[a], pix_t'(PIX_MIN));
        end
    endtask

    task automatic test_gaps();
        randomize_data();
        run_conv(1'b0, 1'b0);
        verify_model();                             // Gap-free baseline against the model
        for (int a = 0; a < NPIX; a++) saved[a] = got[a];
        run_conv(1'b1, 1'b0);                       // Same data, bubbly producers
        for (int a = 0; a < NPIX; a++) begin
            check($sformatf("conv_result_addr %0d hits", a), seen[a], 1);
            check($sformatf("conv_result[%0d] gappy", a), got[a], saved[a]);
        end
    endtask

    task automatic test_busy_start();
        randomize_data();
        run_conv(1'b0, 1'b1);
        verify_model();
        randomize_data();                           // Fresh data for the follow-up run
        run_conv(1'b0, 1'b0);
        verify_model();
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        conv_start   = 1'b0;
        weight       = '0;
        weight_valid = 1'b0;
        pic          = '0;
        pic_valid    = 1'b0;
        errors       = 0;
        checks       = 0;
        result_count = 0;
        finish_count = 0;
        last_addr    = '0;
        void'($urandom(24));
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        test_identity();
        test_random();
        test_saturation();
        test_gaps();
        test_busy_start();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from all runs at gappy worst case
    initial begin
        #(WD_CYCLES * 20);
        $display("timeout: tests did not complete within %0d clock cycles", WD_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- testbench/conv_checker.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_checker (
    input logic            clk,
    input logic            rst_n,
    input logic            need_pic,
    input logic            need_weight,
    input conv_pkg::addr_t conv_result_addr,
    input logic            conv_result_valid,
    input logic            conv_finish
);
    localparam int NPIX = `CONV_PIC_SIZE * `CONV_PIC_SIZE;

    // Only one producer is asked for data at a time
    a_need_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(need_pic && need_weight))
        else $error("need_pic and need_weight high together");

    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        conv_result_valid |-> (int'(conv_result_addr) < NPIX))
        else $error("conv_result_addr outside the image");

    a_finish_valid: assert property (@(posedge clk) disable iff (!rst_n)
        conv_finish |-> conv_result_valid)
        else $error("conv_finish without conv_result_valid");

    a_finish_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        conv_finish |=> !conv_finish)
        else $error("conv_finish longer than one cycle");

    // Outputs stay quiet while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !(need_pic || need_weight || conv_result_valid || conv_finish))
        else $error("outputs active during reset");

endmodule

bind conv_top conv_checker u_checker (
    .clk               (clk),
    .rst_n             (rst_n),
    .need_pic          (need_pic),
    .need_weight       (need_weight),
    .conv_result_addr  (conv_result_addr),
    .conv_result_valid (conv_result_valid),
    .conv_finish       (conv_finish)
);

//--- src/conv_top.sv
`timescale 1ns/1ns

module conv_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            conv_start,         // Ignored while busy
    input  conv_pkg::pix_t  weight,
    input  logic            weight_valid,
    output logic            need_weight,
    input  conv_pkg::pix_t  pic,
    input  logic            pic_valid,
    output logic            need_pic,
    output conv_pkg::pix_t  conv_result,
    output conv_pkg::addr_t conv_result_addr,
    output logic            conv_result_valid,
    output logic            conv_finish         // One cycle, with the last result
);
    import conv_pkg::*;

    logic load_weights;    // Ctrl to PE
    logic weights_done;
    logic clear;           // Ctrl to line buffer
    logic shift_row;
    logic load_row;
    logic row_done;
    col_t scan_col;

    pe_if pif ();          // Window plus tags into the PE

    conv_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .conv_start   (conv_start),
        .load_weights (load_weights),
        .weights_done (weights_done),
        .clear        (clear),
        .shift_row    (shift_row),
        .load_row     (load_row),
        .row_done     (row_done),
        .scan_col     (scan_col),
        .pe           (pif)
    );

    line_buffer u_lbuf (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .shift_row (shift_row),
        .load_row  (load_row),
        .pic       (pic),
        .pic_valid (pic_valid),
        .need_pic  (need_pic),
        .row_done  (row_done),
        .scan_col  (scan_col),
        .win       (pif)
    );

    conv_pe u_pe (
        .clk               (clk),
        .rst_n             (rst_n),
        .load_weights      (load_weights),
        .weight            (weight),
        .weight_valid      (weight_valid),
        .need_weight       (need_weight),
        .weights_done      (weights_done),
        .win               (pif),
        .conv_result       (conv_result),
        .conv_result_addr  (conv_result_addr),
        .conv_result_valid (conv_result_valid),
        .conv_finish       (conv_finish)
    );

endmodule

//--- src/conv_pe.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_pe (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load_weights,       // Restart kernel fill
    input  conv_pkg::pix_t  weight,
    input  logic            weight_valid,
    output logic            need_weight,
    output logic            weights_done,       // With the last accepted weight
    pe_if.pe                win,
    output conv_pkg::pix_t  conv_result,
    output conv_pkg::addr_t conv_result_addr,
    output logic            conv_result_valid,
    output logic            conv_finish
);
    import conv_pkg::*;

    localparam int W      = `CONV_WIDTH;
    localparam int FRAC   = `CONV_FRAC_BITS;
    localparam int KSQ    = `CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE;
    localparam int CNT_W  = $clog2(KSQ + 1);
    localparam int PROD_W = 2 * W;                      // Full product precision
    localparam int SUM_W  = PROD_W + $clog2(KSQ + 1);   // Headroom for KSQ terms
    localparam logic [CNT_W-1:0]        W_LAST  = CNT_W'(KSQ - 1);
    localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'((1 << (W - 1)) - 1);
    localparam logic signed [SUM_W-1:0] SAT_MIN = -SAT_MAX - 1;

    window_t                    kernel;              // Kernel register bank
    logic [CNT_W-1:0]           w_cnt;
    logic                       w_accept;
    logic signed [PROD_W-1:0]   prod [KSQ];          // Stage one products
    logic                       v1, l1;
    addr_t                      a1;
    logic signed [SUM_W-1:0]    sum, shifted;
    pix_t                       sat;

    assign w_accept     = need_weight && weight_valid;
    assign weights_done = w_accept && (w_cnt == W_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            need_weight <= 1'b0;
            w_cnt       <= '0;
        end else if (load_weights) begin
            need_weight <= 1'b1;
            w_cnt       <= '0;
        end else if (w_accept) begin
            need_weight <= (w_cnt != W_LAST);     // Drop after the last one
            w_cnt       <= (w_cnt == W_LAST) ? '0 : w_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (w_accept) kernel[w_cnt] <= weight;   // Row-major fill
    end

    // Stage one, products plus tags
    always_ff @(posedge clk) begin
        a1 <= win.win_addr;
        for (int i = 0; i < KSQ; i++) begin
            prod[i] <= $signed(win.window[i]) * $signed(kernel[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1 <= 1'b0;
            l1 <= 1'b0;
        end else begin
            v1 <= win.win_valid;
            l1 <= win.win_valid && win.win_last;
        end
    end

    // Sum, floor shift, clamp
    always_comb begin
        sum = '0;
        for (int i = 0; i < KSQ; i++) begin
            sum = sum + SUM_W'(prod[i]);          // Sign-extended add
        end
        shifted = sum >>> FRAC;
        if (shifted > SAT_MAX)      sat = pix_t'(SAT_MAX);
        else if (shifted < SAT_MIN) sat = pix_t'(SAT_MIN);
        else                        sat = pix_t'(shifted);
    end

    // Stage two, output registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conv_result       <= '0;
            conv_result_addr  <= '0;
            conv_result_valid <= 1'b0;
            conv_finish       <= 1'b0;
        end else begin
            conv_result       <= sat;
            conv_result_addr  <= a1;
            conv_result_valid <= v1;
            conv_finish       <= v1 && l1;   // Same cycle as last valid
        end
    end

endmodule

//--- src/line_buffer.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module line_buffer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           clear,       // Zero every row
    input  logic           shift_row,   // Move rows up one
    input  logic           load_row,    // Fill window for the bottom row
    input  conv_pkg::pix_t pic,
    input  logic           pic_valid,
    output logic           need_pic,
    output logic           row_done,    // Pulses with the last pixel of a row
    input  conv_pkg::col_t scan_col,
    pe_if.lbuf             win
);
    import conv_pkg::*;

    localparam int   K        = `CONV_KERNEL_SIZE;
    localparam int   P        = `CONV_PIC_SIZE;
    localparam int   PAD      = K / 2;
    localparam int   ROW_LEN  = P + 2 * PAD;     // Image columns plus pad on both sides
    localparam col_t LAST_COL = col_t'(P - 1);

    pix_t rows [K][ROW_LEN];   // Row 0 is the top of the window
    col_t wr_col;              // Next image column in the bottom row
    logic accept;

    assign need_pic = load_row;
    assign accept   = load_row && pic_valid;
    assign row_done = accept && (wr_col == LAST_COL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_col <= '0;
        end else if (clear) begin
            wr_col <= '0;
        end else if (accept) begin
            wr_col <= (wr_col == LAST_COL) ? '0 : wr_col + 1'b1;
        end
    end

    // Pad columns are only ever written with zeros
    always_ff @(posedge clk) begin
        if (clear) begin
            for (int i = 0; i < K; i++) begin
                for (int j = 0; j < ROW_LEN; j++) begin
                    rows[i][j] <= '0;
                end
            end
        end else if (shift_row) begin
            for (int i = 0; i < K - 1; i++) begin
                rows[i] <= rows[i + 1];
            end
            for (int j = 0; j < ROW_LEN; j++) begin
                rows[K - 1][j] <= '0;                 // Fresh row starts empty
            end
        end else if (accept) begin
            rows[K - 1][int'(wr_col) + PAD] <= pic;   // Skip left pad
        end
    end

    // Window taken straight from the store, left edge at scan_col
    always_comb begin
        for (int i = 0; i < K; i++) begin
            for (int j = 0; j < K; j++) begin
                win.window[i * K + j] = rows[i][int'(scan_col) + j];
            end
        end
    end

endmodule

//--- src/conv_ctrl.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           conv_start,    // Honoured in IDLE only
    output logic           load_weights,  // Arms the PE kernel bank
    input  logic           weights_done,  // Last weight taken
    output logic           clear,         // Zero the whole line buffer
    output logic           shift_row,     // Rows move up, bottom zeroed
    output logic           load_row,      // Buffer may take pixels
    input  logic           row_done,      // Bottom row full
    output conv_pkg::col_t scan_col,      // Left edge of window
    pe_if.ctrl             pe
);
    import conv_pkg::*;

    localparam int    K         = `CONV_KERNEL_SIZE;
    localparam int    P         = `CONV_PIC_SIZE;
    localparam int    PAD       = K / 2;
    localparam int    ROW_W     = $clog2(P + PAD + 1);  // Counts past image for zero rows
    localparam addr_t LAST_ADDR = addr_t'(P * P - 1);
    localparam col_t  LAST_COL  = col_t'(P - 1);

    ctrl_state_t      state, state_n;
    col_t             col, col_n;              // Scan column
    addr_t            addr, addr_n;            // Address of current window
    logic [ROW_W-1:0] next_img, next_img_n;    // Image row that goes in next
    logic             shifted, shifted_n;      // Shift already done in this LOAD_ROW
    logic             drain_cnt, drain_cnt_n;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            col       <= '0;
            addr      <= '0;
            next_img  <= '0;
            shifted   <= 1'b0;
            drain_cnt <= 1'b0;
        end else begin
            state     <= state_n;
            col       <= col_n;
            addr      <= addr_n;
            next_img  <= next_img_n;
            shifted   <= shifted_n;
            drain_cnt <= drain_cnt_n;
        end
    end

    always_comb begin
        state_n      = state;
        col_n        = col;
        addr_n       = addr;
        next_img_n   = next_img;
        shifted_n    = shifted;
        drain_cnt_n  = drain_cnt;
        clear        = 1'b0;
        load_weights = 1'b0;
        shift_row    = 1'b0;
        load_row     = 1'b0;
        pe.win_valid = 1'b0;
        case (state)
            IDLE: begin
                if (conv_start) begin
                    clear        = 1'b1;
                    load_weights = 1'b1;
                    col_n        = '0;
                    addr_n       = '0;
                    next_img_n   = '0;
                    shifted_n    = 1'b0;
                    state_n      = LOAD_W;
                end
            end
            LOAD_W: begin
                if (weights_done) state_n = LOAD_ROW;
            end
            LOAD_ROW: begin
                if (!shifted) begin
                    shift_row = 1'b1;                       // Every row entry starts with a shift
                    if (next_img >= ROW_W'(P)) begin
                        next_img_n = next_img + 1'b1;       // Row below image stays zero
                        state_n    = SCAN;
                    end else begin
                        shifted_n = 1'b1;
                    end
                end else begin
                    load_row = 1'b1;
                    if (row_done) begin
                        shifted_n  = 1'b0;
                        next_img_n = next_img + 1'b1;
                        // Prefill needs rows 0..PAD before the first scan
                        if (next_img >= ROW_W'(PAD)) state_n = SCAN;
                    end
                end
            end
            SCAN: begin
                pe.win_valid = 1'b1;
                addr_n       = addr + 1'b1;
                if (col == LAST_COL) begin
                    col_n = '0;
                    if (addr == LAST_ADDR) begin
                        drain_cnt_n = 1'b0;
                        state_n     = DRAIN;
                    end else begin
                        state_n = LOAD_ROW;
                    end
                end else begin
                    col_n = col + 1'b1;
                end
            end
            DRAIN: begin
                drain_cnt_n = 1'b1;                         // Two cycles covers PE latency
                if (drain_cnt) state_n = IDLE;
            end
            default: state_n = IDLE;
        endcase
    end

    assign scan_col    = col;
    assign pe.win_addr = addr;
    assign pe.win_last = (state == SCAN) && (addr == LAST_ADDR);

endmodule

//--- src/pe_if.sv
`timescale 1ns/1ns

interface pe_if;
    import conv_pkg::*;

    logic    win_valid;   // Window presented this cycle, never stalled
    addr_t   win_addr;    // Result address of this window
    logic    win_last;    // Last window of the image
    window_t window;      // Row-major pixels under the kernel

    // Control side tags the window
    modport ctrl (output win_valid, win_addr, win_last);

    // Line buffer supplies the pixels
    modport lbuf (output window);

    // PE consumes everything
    modport pe (input win_valid, win_addr, win_last, window);

endinterface

//--- src/conv_pkg.sv
`include "conv_cfg.svh"

package conv_pkg;

    typedef logic signed [`CONV_WIDTH-1:0] pix_t;      // Pixel, weight or result

    // Row-major K*K window, also used for the kernel bank
    typedef pix_t [`CONV_KERNEL_SIZE*`CONV_KERNEL_SIZE-1:0] window_t;

    typedef logic [$clog2(`CONV_PIC_SIZE*`CONV_PIC_SIZE)-1:0] addr_t;  // Row*P + col
    typedef logic [$clog2(`CONV_PIC_SIZE)-1:0] col_t;                  // Image column

    typedef enum logic [2:0] {
        IDLE,       // Waiting for conv_start
        LOAD_W,     // Kernel weights streaming in
        LOAD_ROW,   // Shift, then fill bottom row (or zero row)
        SCAN,       // One window per cycle across the row
        DRAIN       // PE pipeline emptying
    } ctrl_state_t;

endpackage

//--- src/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Pixel, weight and result width
`define CONV_WIDTH 8

// Fixed-point fraction, Q4.4 by default
`define CONV_FRAC_BITS 4

// Kernel side, odd only so the window has a centre
`define CONV_KERNEL_SIZE 3

`define CONV_PIC_SIZE 8   // Square image side

`endif
